// ==== hdl/lsu_config.svh ====
// Load/store unit sizing macros: bank count, bank depth, data and lane widths
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// ============================================================
// Bank organisation
// ============================================================

// Interleaved banks, word granularity
`define LSU_NUM_BANKS 4
`define LSU_BANK_SEL_BITS 2

// Words per bank as log2
`define LSU_BANK_DEPTH_LOG2 6

// ============================================================
// Data path
// ============================================================

`define LSU_XLEN 32
`define LSU_BYTE_LANES 4

`endif

// ==== hdl/lsu_pipe_pkg.sv ====
// Pipeline record types: access width, register index, execute and memory stage records
`include "lsu_config.svh"

package lsu_pipe_pkg;

	// Encoding follows the low bits of the load/store funct3
	typedef enum logic [1:0] {
		MEM_BYTE = 2'b00,
		MEM_HALF = 2'b01,
		MEM_WORD = 2'b10
	} mem_width_t;

	typedef logic [4:0] reg_index_t;

	// Record from execute, held stable until retired
	typedef struct packed {
		logic                 strobe;
		logic [`LSU_XLEN-1:0] pc;
		logic [`LSU_XLEN-1:0] rd;
		reg_index_t           inst_rd;
		logic                 mem_read;
		logic                 mem_write;
		mem_width_t           mem_width;
		logic                 mem_signed;
		logic [`LSU_XLEN-1:0] mem_address;
	} execute_data_t;

	// Record towards write-back
	typedef struct packed {
		logic                 strobe;
		logic [`LSU_XLEN-1:0] pc;
		logic [`LSU_XLEN-1:0] rd;
		reg_index_t           inst_rd;
	} memory_data_t;

endpackage

// ==== hdl/lsu_bank_pkg.sv ====
// Bank addressing types: word index, bank number and the split address union
`include "lsu_config.svh"

package lsu_bank_pkg;

	typedef logic [`LSU_BANK_DEPTH_LOG2-1:0] bank_index_t;
	typedef logic [`LSU_BANK_SEL_BITS-1:0] bank_sel_t;

	// Upper bits left over above the bank index
	localparam int UPPER_BITS = `LSU_XLEN - 2 - `LSU_BANK_SEL_BITS - `LSU_BANK_DEPTH_LOG2;

	// Bank select sits right above the byte offset,
	// so consecutive words land in consecutive banks
	typedef struct packed {
		logic [UPPER_BITS-1:0] upper;
		bank_index_t           index;
		bank_sel_t             sel;
		logic [1:0]            offset;
	} lsu_addr_fields_t;

	typedef union packed {
		logic [`LSU_XLEN-1:0] raw;
		lsu_addr_fields_t     f;
	} lsu_addr_u;

endpackage

// ==== hdl/bank_if.sv ====
// Bank request/response interface with dispatch, bank and collect modports
`timescale 1ns/100ps
`include "lsu_config.svh"

interface bank_if;

	logic                          request;
	logic                          rw;
	lsu_bank_pkg::bank_index_t     index;
	logic [`LSU_XLEN-1:0]          wdata;
	logic [`LSU_BYTE_LANES-1:0]    wmask;
	logic [`LSU_XLEN-1:0]          rdata;
	logic                          ready;

	modport dispatch (
		output request, rw, index, wdata, wmask
	);

	modport bank (
		input  request, rw, index, wdata, wmask,
		output rdata, ready
	);

	modport collect (
		input request, rdata, ready
	);

endinterface

// ==== hdl/lsu_dispatch.sv ====
// Load/store dispatch: new-record detection, store lane placement, bank request fan-out
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_dispatch (
	input  logic                        i_clock,
	input  logic                        i_rst_n,
	input  lsu_pipe_pkg::execute_data_t i_data,
	input  logic                        i_done,
	output logic                        o_busy,
	output logic                        o_pass,
	output lsu_bank_pkg::bank_sel_t     o_sel,
	output lsu_pipe_pkg::mem_width_t    o_width,
	output logic                        o_signed,
	output logic [1:0]                  o_offset,
	bank_if.dispatch                    banks [`LSU_NUM_BANKS]
);

	typedef enum logic {
		ST_IDLE,
		ST_WAIT
	} state_t;

	state_t                     state;
	logic                       last_strobe;
	logic                       new_rec;
	logic                       is_mem;
	logic                       issue;
	lsu_bank_pkg::lsu_addr_u    addr;
	logic [`LSU_XLEN-1:0]       st_wdata;
	logic [`LSU_BYTE_LANES-1:0] st_wmask;

	assign addr.raw = i_data.mem_address;

	assign new_rec = (i_data.strobe != last_strobe);
	assign is_mem  = i_data.mem_read || i_data.mem_write;
	assign issue   = (state == ST_IDLE) && new_rec && is_mem;
	assign o_pass  = (state == ST_IDLE) && new_rec && !is_mem;
	assign o_busy  = new_rec && is_mem;

	// ============================================================
	// Store lane placement
	// ============================================================

	always_comb begin
		st_wdata = i_data.rd;
		st_wmask = '0;
		case (i_data.mem_width)
			lsu_pipe_pkg::MEM_BYTE: begin
				st_wdata = {4{i_data.rd[7:0]}};
				st_wmask = 4'b0001 << addr.f.offset;
			end
			lsu_pipe_pkg::MEM_HALF: begin
				st_wdata = {2{i_data.rd[15:0]}};
				// Odd offset: nothing written
				if (!addr.f.offset[0])
					st_wmask = addr.f.offset[1] ? 4'b1100 : 4'b0011;
			end
			lsu_pipe_pkg::MEM_WORD: begin
				st_wmask = 4'b1111;
			end
			default: begin
				st_wmask = '0;
			end
		endcase
	end

	// Only the addressed bank sees the request
	for (genvar g = 0; g < `LSU_NUM_BANKS; g++) begin : g_req
		assign banks[g].request = issue && (addr.f.sel == lsu_bank_pkg::bank_sel_t'(g));
		assign banks[g].rw      = i_data.mem_write;
		assign banks[g].index   = addr.f.index;
		assign banks[g].wdata   = st_wdata;
		assign banks[g].wmask   = st_wmask;
	end

	// ============================================================
	// Control state
	// ============================================================

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state       <= ST_IDLE;
			last_strobe <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (issue)
						state <= ST_WAIT;
					if (o_pass)
						last_strobe <= i_data.strobe;
				end
				ST_WAIT: begin
					if (i_done) begin
						state       <= ST_IDLE;
						last_strobe <= i_data.strobe;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Access details for the response path
	always_ff @(posedge i_clock) begin
		if (issue) begin
			o_sel    <= addr.f.sel;
			o_width  <= i_data.mem_width;
			o_signed <= i_data.mem_signed;
			o_offset <= addr.f.offset;
		end
	end

endmodule

// ==== hdl/data_bank.sv ====
// Data bank: byte-masked single-port RAM with registered read data and ready pulse
`timescale 1ns/100ps
`include "lsu_config.svh"

module data_bank (
	input  logic    i_clock,
	input  logic    i_rst_n,
	bank_if.bank    bus
);

	localparam int DEPTH = 1 << `LSU_BANK_DEPTH_LOG2;

	logic [`LSU_XLEN-1:0] mem [DEPTH];

	// ============================================================
	// Storage
	// ============================================================

	always_ff @(posedge i_clock) begin
		if (bus.request) begin
			if (bus.rw) begin
				for (int b = 0; b < `LSU_BYTE_LANES; b++) begin
					if (bus.wmask[b])
						mem[bus.index][b*8 +: 8] <= bus.wdata[b*8 +: 8];
				end
			end else begin
				bus.rdata <= mem[bus.index];
			end
		end
	end

	// ============================================================
	// Response
	// ============================================================

	// One ready per request, reads and writes alike
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n)
			bus.ready <= 1'b0;
		else
			bus.ready <= bus.request;
	end

endmodule

// ==== hdl/lsu_collect.sv ====
// Load/store collect: bank response select, load alignment and extension, result register
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_collect (
	input  logic                        i_clock,
	input  logic                        i_rst_n,
	input  lsu_pipe_pkg::execute_data_t i_data,
	input  logic                        i_pass,
	input  lsu_bank_pkg::bank_sel_t     i_sel,
	input  lsu_pipe_pkg::mem_width_t    i_width,
	input  logic                        i_signed,
	input  logic [1:0]                  i_offset,
	bank_if.collect                     banks [`LSU_NUM_BANKS],
	output logic                        o_done,
	output lsu_pipe_pkg::memory_data_t  o_data
);

	logic [`LSU_NUM_BANKS-1:0] ready_vec;
	logic [`LSU_XLEN-1:0]      rdata_vec [`LSU_NUM_BANKS];
	logic [`LSU_XLEN-1:0]      sel_rdata;
	logic [`LSU_XLEN-1:0]      shifted;
	logic [`LSU_XLEN-1:0]      load_value;

	logic                      out_strobe;
	logic [`LSU_XLEN-1:0]      out_pc;
	logic [`LSU_XLEN-1:0]      out_rd;
	lsu_pipe_pkg::reg_index_t  out_inst_rd;

	for (genvar g = 0; g < `LSU_NUM_BANKS; g++) begin : g_rsp
		assign ready_vec[g] = banks[g].ready;
		assign rdata_vec[g] = banks[g].rdata;
	end

	assign sel_rdata = rdata_vec[i_sel];
	assign o_done    = ready_vec[i_sel];

	// ============================================================
	// Load formatting
	// ============================================================

	always_comb begin
		shifted = sel_rdata >> {i_offset, 3'b000};
		case (i_width)
			lsu_pipe_pkg::MEM_BYTE:
				load_value = {{(`LSU_XLEN-8){i_signed & shifted[7]}}, shifted[7:0]};
			lsu_pipe_pkg::MEM_HALF:
				load_value = {{(`LSU_XLEN-16){i_signed & shifted[15]}}, shifted[15:0]};
			default:
				load_value = shifted;
		endcase
	end

	// ============================================================
	// Result record
	// ============================================================

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n)
			out_strobe <= 1'b0;
		else if (i_pass || o_done)
			out_strobe <= ~out_strobe;
	end

	always_ff @(posedge i_clock) begin
		if (i_pass || o_done) begin
			out_pc      <= i_data.pc;
			out_inst_rd <= i_data.inst_rd;
			// Stores and passed records keep rd
			out_rd      <= (o_done && i_data.mem_read) ? load_value : i_data.rd;
		end
	end

	assign o_data = '{strobe: out_strobe, pc: out_pc, rd: out_rd, inst_rd: out_inst_rd};

endmodule

// ==== hdl/lsu_top.sv ====
// Load/store unit top: dispatch, interleaved data banks and collect
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_top (
	input  logic                        i_clock,
	input  logic                        i_rst_n,
	input  lsu_pipe_pkg::execute_data_t i_data,
	output logic                        o_busy,
	output lsu_pipe_pkg::memory_data_t  o_data
);

	logic                     pass;
	logic                     done;
	lsu_bank_pkg::bank_sel_t  sel;
	lsu_pipe_pkg::mem_width_t width;
	logic                     is_signed;
	logic [1:0]               offset;

	bank_if banks [`LSU_NUM_BANKS] ();

	lsu_dispatch u_dispatch (
		.i_clock  (i_clock),
		.i_rst_n  (i_rst_n),
		.i_data   (i_data),
		.i_done   (done),
		.o_busy   (o_busy),
		.o_pass   (pass),
		.o_sel    (sel),
		.o_width  (width),
		.o_signed (is_signed),
		.o_offset (offset),
		.banks    (banks)
	);

	// ============================================================
	// Data banks
	// ============================================================

	for (genvar g = 0; g < `LSU_NUM_BANKS; g++) begin : g_bank
		data_bank u_bank (
			.i_clock (i_clock),
			.i_rst_n (i_rst_n),
			.bus     (banks[g])
		);
	end

	lsu_collect u_collect (
		.i_clock  (i_clock),
		.i_rst_n  (i_rst_n),
		.i_data   (i_data),
		.i_pass   (pass),
		.i_sel    (sel),
		.i_width  (width),
		.i_signed (is_signed),
		.i_offset (offset),
		.banks    (banks),
		.o_done   (done),
		.o_data   (o_data)
	);

endmodule

// ==== verif/tb_clock.sv ====
// Testbench clock and reset source
`timescale 1ns/100ps

module tb_clock #(
	parameter int HALF_PERIOD  = 4,
	parameter int RESET_CYCLES = 4
) (
	output logic o_clock,
	output logic o_rst_n
);

	initial begin
		o_clock = 1'b0;
		forever #HALF_PERIOD o_clock = ~o_clock;
	end

	// Release just after an edge, like the other inputs
	initial begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clock);
		#1 o_rst_n = 1'b1;
	end

endmodule

// ==== verif/tb_lsu.sv ====
// Load/store unit testbench: stimulus, byte memory model, reference function and checks
`timescale 1ns/100ps
`include "lsu_config.svh"

module tb_lsu;

	localparam int ADDR_BITS = `LSU_BANK_DEPTH_LOG2 + `LSU_BANK_SEL_BITS + 2;

	logic                        clock;
	logic                        rst_n;
	logic                        busy;
	lsu_pipe_pkg::execute_data_t data;
	lsu_pipe_pkg::memory_data_t  result;
	lsu_pipe_pkg::memory_data_t  exp_q [$];
	logic [7:0]                  ref_mem [1 << ADDR_BITS];
	integer                      seed = 32'h720b_8871;

	tb_clock clk0 (.o_clock(clock), .o_rst_n(rst_n));

	lsu_top dut0 (
		.i_clock (clock),
		.i_rst_n (rst_n),
		.i_data  (data),
		.o_busy  (busy),
		.o_data  (result)
	);

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_data(input lsu_pipe_pkg::memory_data_t got,
		input lsu_pipe_pkg::memory_data_t exp);
		if (got !== exp)
			stop_run($sformatf("error %0t: result %h, expected %h", $time, got, exp));
	endtask

	task automatic check_busy(input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("error %0t: o_busy %b, expected %b", $time, got, exp));
	endtask

	// Stores update the byte model; loads shift the aligned word by the offset and extend
	function automatic lsu_pipe_pkg::memory_data_t reference_access(
		input lsu_pipe_pkg::execute_data_t rec);
		lsu_pipe_pkg::memory_data_t res;
		logic [ADDR_BITS-1:0] a;
		logic [ADDR_BITS-1:0] s;
		logic [31:0] word;
		int k;
		a = rec.mem_address[ADDR_BITS-1:0];
		s = (rec.mem_width == lsu_pipe_pkg::MEM_WORD) ? {a[ADDR_BITS-1:2], 2'b00} : a;
		res = '{strobe: rec.strobe, pc: rec.pc, rd: rec.rd, inst_rd: rec.inst_rd};
		// A half at an odd address writes nothing
		if (rec.mem_write && !(rec.mem_width == lsu_pipe_pkg::MEM_HALF && a[0])) begin
			for (k = 0; k < (1 << rec.mem_width); k++)
				ref_mem[s + ADDR_BITS'(k)] = rec.rd[8*k +: 8];
		end
		for (k = 0; k < 4; k++)
			word[8*k +: 8] = ref_mem[{a[ADDR_BITS-1:2], 2'(k)}];
		word = word >> (8 * a[1:0]);
		if (rec.mem_read && rec.mem_width == lsu_pipe_pkg::MEM_BYTE)
			res.rd = (rec.mem_signed && word[7]) ? word | 32'hffff_ff00 : word & 32'h0000_00ff;
		else if (rec.mem_read && rec.mem_width == lsu_pipe_pkg::MEM_HALF)
			res.rd = (rec.mem_signed && word[15]) ? word | 32'hffff_0000 : word & 32'h0000_ffff;
		else if (rec.mem_read)
			res.rd = word;
		return res;
	endfunction

	// Drives one record and waits until the compare process has retired it
	task automatic run_op(input logic rd_en, input logic wr_en, input int width,
		input logic sgn, input logic [31:0] addr, input logic [31:0] value);
		lsu_pipe_pkg::execute_data_t rec;
		int waited;
		rec = '{strobe: ~data.strobe, pc: $random(seed), rd: value,
			inst_rd: 5'($random(seed)), mem_read: rd_en, mem_write: wr_en,
			mem_width: lsu_pipe_pkg::mem_width_t'(2'(width)),
			mem_signed: sgn, mem_address: addr};
		exp_q.push_back(reference_access(rec));
		data = rec;
		waited = 0;
		while (exp_q.size() != 0) begin
			@(posedge clock);
			waited++;
			if (waited > 8)
				stop_run("Timeout: a record was not retired");
		end
		#1;
	endtask

	// ============================================================
	// Compare at the falling edge
	// ============================================================

	initial begin : compare
		logic last_strobe;
		logic mem_op;
		int cycles;
		last_strobe = 1'b0;
		forever begin
			cycles = 0;
			while (exp_q.size() == 0) begin
				@(negedge clock);
				cycles++;
				if (cycles > 100)
					stop_run("Timeout: no record arrived for checking");
			end
			mem_op = data.mem_read || data.mem_write;
			cycles = 0;
			while (result.strobe == last_strobe) begin
				check_busy(busy, mem_op);
				@(negedge clock);
				cycles++;
				if (cycles > 4)
					stop_run("Timeout: the output strobe did not toggle");
			end
			if (cycles != (mem_op ? 2 : 1))
				stop_run($sformatf("error %0t: retired after %0d cycles", $time, cycles));
			check_data(result, exp_q.pop_front());
			check_busy(busy, 1'b0);
			last_strobe = result.strobe;
		end
	end

	initial begin : stimulus
		int i;
		logic [31:0] base;
		logic [31:0] r;
		data = '0;
		i = 0;
		while (rst_n !== 1'b1) begin
			@(posedge clock);
			i++;
			if (i > 10)
				stop_run("Timeout: reset was not released");
		end
		#1;
		// Unique word pattern written to all banks and read back
		for (i = 0; i < (1 << ADDR_BITS); i += 4)
			run_op(1'b0, 1'b1, 2, 1'b0, i, (i * 32'h0001_0003) ^ 32'hc3a5_0f96);
		for (i = 0; i < (1 << ADDR_BITS); i += 4)
			run_op(1'b1, 1'b0, 2, 1'b0, i, $random(seed));
		// Bytes then halves at each offset with a word read after each
		base = 32'h0000_0128;
		for (i = 0; i < 8; i++) begin
			run_op(1'b0, 1'b1, i / 4, 1'b0, base + i % 4, $random(seed));
			run_op(1'b1, 1'b0, 2, 1'b0, base, $random(seed));
		end
		// Top bit clear in the low bytes and set in the high ones
		run_op(1'b0, 1'b1, 2, 1'b0, base, 32'h80ff_7f01);
		for (i = 0; i < 16; i++)
			run_op(1'b1, 1'b0, i / 8, i[2], base + i % 4, $random(seed));
		// Random mix with about half pass-through records
		for (i = 0; i < 600; i++) begin
			r = $random(seed);
			run_op(r[1:0] == 2'd1, r[1:0] == 2'd2, r[3:2] % 3, r[4],
				$random(seed), $random(seed));
		end
		$display("Test passed");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/lsu_pipe_pkg.sv
hdl/lsu_bank_pkg.sv
hdl/bank_if.sv
hdl/lsu_dispatch.sv
hdl/data_bank.sv
hdl/lsu_collect.sv
hdl/lsu_top.sv
verif/tb_clock.sv
verif/tb_lsu.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_lsu -f verilog.f -o tb_lsu_sim
./obj_dir/tb_lsu_sim
